//--- hdl/display_pkg.sv
package display_pkg;

    //////////////////////////////////////////////////
    // screen counters and color

    localparam int hcount_w  = 11;    // 0 at left
    localparam int vcount_w  = 10;    // 0 at top
    localparam int rgb_w     = 12;    // 4 bits per channel

    localparam int num_obj    = 5;    // object slots on screen at once
    localparam int num_hearts = 3;
    localparam int score_max  = 999;  // three digits, larger scores clamp

    //////////////////////////////////////////////////
    // sprite geometry

    // player stays at a fixed column, only y moves
    localparam int char_x = 10;
    localparam int char_w = 45;
    localparam int char_h = 40;

    localparam int coll_w  = 15;
    localparam int coll_h  = 16;
    localparam int shark_w = 40;
    localparam int shark_h = 20;

    // health row in the top left corner
    localparam int heart_y  = 20;
    localparam int heart_w  = 40;
    localparam int heart_h  = 40;
    localparam int heart_x0 = 20;     // left edge of heart 0
    localparam int heart_dx = 60;     // pitch between hearts

    //////////////////////////////////////////////////
    // flat sprite colors

    localparam logic [rgb_w-1:0] color_char        = 12'hFA0;
    localparam logic [rgb_w-1:0] color_coll        = 12'hFF0;
    localparam logic [rgb_w-1:0] color_shark       = 12'h888;
    localparam logic [rgb_w-1:0] color_heart_full  = 12'hF00;
    localparam logic [rgb_w-1:0] color_heart_empty = 12'h444;
    localparam logic [rgb_w-1:0] color_sky         = 12'hBDF;  // above wave
    localparam logic [rgb_w-1:0] color_water       = 12'h00F;  // below wave

    // object kind field, kinds 2 and 3 draw nothing
    localparam logic [1:0] kind_coll  = 2'd0;
    localparam logic [1:0] kind_shark = 2'd1;

    // object slot as the game logic sends it, all zero means empty
    typedef struct packed {
        logic [1:0]          kind;
        logic [hcount_w-1:0] x;
        logic [vcount_w-1:0] y;
    } obj_word_t;

    // a sprite placed for this frame
    typedef struct packed {
        logic                valid;
        logic [hcount_w-1:0] x;  // left edge
        logic [vcount_w-1:0] y;  // top edge
    } place_t;

    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } digits_t;

endpackage

//--- hdl/frame_decode.sv
module frame_decode (
    input  logic                                 vclock,
    input  logic                                 reset,
    input  logic                                 vsync,   // active low
    input  logic [display_pkg::vcount_w-1:0]     p_vpos,  // player top edge
    input  display_pkg::obj_word_t               obj_words [display_pkg::num_obj],
    input  logic [9:0]                           score,
    input  logic [1:0]                           health,
    output display_pkg::place_t                  char_place,
    output display_pkg::place_t                  coll_places [display_pkg::num_obj],
    output display_pkg::place_t                  shark_places [display_pkg::num_obj],
    output logic [display_pkg::num_hearts-1:0]   heart_full,
    output display_pkg::digits_t                 digits
);
    import display_pkg::*;

    logic                  vsync_q;     // vsync one cycle back
    logic                  vsync_fall;
    logic [9:0]            score_c;     // clamped score
    logic [15:0]           hund_prod;
    logic [3:0]            hund;
    logic [6:0]            rem;         // score mod 100
    logic [14:0]           tens_prod;
    logic [3:0]            tens;
    logic [3:0]            ones;
    logic [num_hearts-1:0] fill;

    // frame boundary, first low sample after reset counts too
    assign vsync_fall = ~vsync & vsync_q;

    //////////////////////////////////////////////////
    // score to decimal

    assign score_c = (score > 10'(score_max)) ? 10'(score_max) : score;

    // n*41 >> 12 is floor(n/100) for n up to 999
    assign hund_prod = 16'(score_c) * 16'd41;
    assign hund      = hund_prod[15:12];
    assign rem       = 7'(score_c - hund * 10'd100);

    // r*205 >> 11 is floor(r/10) for r up to 99
    assign tens_prod = 15'(rem) * 15'd205;
    assign tens      = tens_prod[14:11];
    assign ones      = 4'(rem - tens * 7'd10);

    // heart k lit while health > k
    for (genvar k = 0; k < num_hearts; k++) begin : g_fill
        assign fill[k] = health > 2'(k);
    end

    //////////////////////////////////////////////////
    // frame latch

    always_ff @(posedge vclock) begin
        if (reset) begin
            vsync_q          <= 1'b1;
            char_place.valid <= 1'b0;
            heart_full       <= '0;
            digits           <= '0;
            for (int i = 0; i < num_obj; i++) begin
                coll_places[i].valid  <= 1'b0;
                shark_places[i].valid <= 1'b0;
            end
        end else begin
            vsync_q <= vsync;
            if (vsync_fall) begin
                char_place <= '{valid: 1'b1, x: hcount_w'(char_x), y: p_vpos};
                for (int i = 0; i < num_obj; i++) begin
                    // same slot feeds both lists, kind picks at most one
                    coll_places[i].valid  <= (obj_words[i] != '0)
                                             && (obj_words[i].kind == kind_coll);
                    coll_places[i].x      <= obj_words[i].x;
                    coll_places[i].y      <= obj_words[i].y;
                    shark_places[i].valid <= (obj_words[i] != '0)
                                             && (obj_words[i].kind == kind_shark);
                    shark_places[i].x     <= obj_words[i].x;
                    shark_places[i].y     <= obj_words[i].y;
                end
                heart_full <= fill;
                digits     <= '{hundreds: hund, tens: tens, ones: ones};
            end
        end
    end

    // the multiply-shift digit split must land on a decimal digit
    assert property (@(posedge vclock) disable iff (reset)
        vsync_fall |=> (digits.hundreds < 4'd10) && (digits.tens < 4'd10)
                       && (digits.ones < 4'd10));

endmodule

//--- hdl/sprite_hit_array.sv
module sprite_hit_array #(
    parameter int count = 1,   // sprites in this group
    parameter int spr_w = 8,   // box width in pixels
    parameter int spr_h = 8    // box height in pixels
) (
    input  logic                             vclock,
    input  logic                             reset,
    input  display_pkg::place_t              places [count],
    input  logic [display_pkg::hcount_w-1:0] hcount,
    input  logic [display_pkg::vcount_w-1:0] vcount,
    output logic [count-1:0]                 hits
);
    import display_pkg::*;

    logic [count-1:0] in_box;  // combinational box test per sprite

    //////////////////////////////////////////////////
    // box test, one per placement

    for (genvar i = 0; i < count; i++) begin : g_box
        logic [hcount_w:0] x_end;  // one extra bit, box may run off screen
        logic [vcount_w:0] y_end;
        logic              in_x;
        logic              in_y;

        assign x_end = {1'b0, places[i].x} + (hcount_w + 1)'(spr_w - 1);  // last column
        assign y_end = {1'b0, places[i].y} + (vcount_w + 1)'(spr_h - 1);  // last row

        assign in_x = (hcount >= places[i].x) && ({1'b0, hcount} <= x_end);
        assign in_y = (vcount >= places[i].y) && ({1'b0, vcount} <= y_end);

        assign in_box[i] = places[i].valid && in_x && in_y;
    end

    // one pipeline stage, lines up with the wave compare downstream
    always_ff @(posedge vclock) begin
        if (reset) begin
            hits <= '0;
        end else begin
            hits <= in_box;
        end
    end

endmodule

//--- hdl/pixel_compose.sv
module pixel_compose (
    input  logic                               vclock,
    input  logic                               reset,
    input  logic                               char_hit,
    input  logic [display_pkg::num_obj-1:0]    coll_hits,
    input  logic [display_pkg::num_obj-1:0]    shark_hits,
    input  logic [display_pkg::num_hearts-1:0] heart_hits,
    input  logic [display_pkg::num_hearts-1:0] heart_full,
    input  logic [display_pkg::vcount_w-1:0]   vcount,
    input  logic [display_pkg::vcount_w-1:0]   wave_prof,  // wave height at this column
    output logic [display_pkg::rgb_w-1:0]      rgb
);
    import display_pkg::*;

    logic             above_q;      // pixel at or above the wave line
    logic             primed;       // first stage holds a real pixel
    logic [rgb_w-1:0] heart_color;
    logic [rgb_w-1:0] color_next;

    //////////////////////////////////////////////////
    // stage 1, same edge as the sprite hits

    always_ff @(posedge vclock) begin
        if (reset) begin
            primed <= 1'b0;
        end else begin
            primed <= 1'b1;
        end
    end

    always_ff @(posedge vclock) begin
        above_q <= (vcount <= wave_prof);  // smaller vcount is higher on screen
    end

    //////////////////////////////////////////////////
    // stage 2, priority pick

    // lowest heart index wins where boxes touch
    always_comb begin
        heart_color = color_heart_empty;
        for (int k = num_hearts - 1; k >= 0; k--) begin
            if (heart_hits[k]) begin
                heart_color = heart_full[k] ? color_heart_full : color_heart_empty;
            end
        end
    end

    always_comb begin
        if (char_hit) begin
            color_next = color_char;        // player always on top
        end else if (|coll_hits) begin
            color_next = color_coll;
        end else if (|shark_hits) begin
            color_next = color_shark;
        end else if (|heart_hits) begin
            color_next = heart_color;       // hud under the objects
        end else if (above_q) begin
            color_next = color_sky;
        end else begin
            color_next = color_water;
        end
    end

    always_ff @(posedge vclock) begin
        if (reset) begin
            rgb <= '0;                      // black while the pipe refills
        end else begin
            rgb <= primed ? color_next : '0;
        end
    end

    // black output for the first pixel once reset lets go
    assert property (@(posedge vclock) $fell(reset) |=> (rgb == '0));

endmodule

//--- hdl/display_top.sv
module display_top (
    input  logic                             vclock,
    input  logic                             reset,
    input  logic                             vsync,      // active low
    input  logic [display_pkg::hcount_w-1:0] hcount,
    input  logic [display_pkg::vcount_w-1:0] vcount,
    input  logic [display_pkg::vcount_w-1:0] wave_prof,
    input  logic [display_pkg::vcount_w-1:0] p_vpos,
    input  display_pkg::obj_word_t           obj_words [display_pkg::num_obj],
    input  logic [9:0]                       score,
    input  logic [1:0]                       health,
    output logic [display_pkg::rgb_w-1:0]    rgb,
    output display_pkg::digits_t             digits
);
    import display_pkg::*;

    place_t                char_places [1];         // single player sprite
    place_t                coll_places [num_obj];
    place_t                shark_places [num_obj];
    place_t                heart_places [num_hearts];
    logic [num_hearts-1:0] heart_full;
    logic                  char_hit;
    logic [num_obj-1:0]    coll_hit;
    logic [num_obj-1:0]    shark_hit;
    logic [num_hearts-1:0] heart_hit;

    // hearts never move
    for (genvar k = 0; k < num_hearts; k++) begin : g_heart
        assign heart_places[k] = '{valid: 1'b1,
                                   x: hcount_w'(heart_x0 + k * heart_dx),
                                   y: vcount_w'(heart_y)};
    end

    //////////////////////////////////////////////////
    // frame decode

    frame_decode decode (
        .vclock(vclock), .reset(reset), .vsync(vsync),
        .p_vpos(p_vpos), .obj_words(obj_words), .score(score), .health(health),
        .char_place(char_places[0]), .coll_places(coll_places),
        .shark_places(shark_places), .heart_full(heart_full), .digits(digits)
    );

    //////////////////////////////////////////////////
    // hit tests, one group per sprite size

    sprite_hit_array #(.count(1), .spr_w(char_w), .spr_h(char_h)) char_hits (
        .vclock(vclock), .reset(reset), .places(char_places),
        .hcount(hcount), .vcount(vcount), .hits(char_hit)
    );

    sprite_hit_array #(.count(num_obj), .spr_w(coll_w), .spr_h(coll_h)) coll_hits (
        .vclock(vclock), .reset(reset), .places(coll_places),
        .hcount(hcount), .vcount(vcount), .hits(coll_hit)
    );

    sprite_hit_array #(.count(num_obj), .spr_w(shark_w), .spr_h(shark_h)) shark_hits (
        .vclock(vclock), .reset(reset), .places(shark_places),
        .hcount(hcount), .vcount(vcount), .hits(shark_hit)
    );

    sprite_hit_array #(.count(num_hearts), .spr_w(heart_w), .spr_h(heart_h)) heart_hits (
        .vclock(vclock), .reset(reset), .places(heart_places),
        .hcount(hcount), .vcount(vcount), .hits(heart_hit)
    );

    // final color, two clocks after the pixel counters
    pixel_compose compose (
        .vclock(vclock), .reset(reset),
        .char_hit(char_hit), .coll_hits(coll_hit), .shark_hits(shark_hit),
        .heart_hits(heart_hit), .heart_full(heart_full),
        .vcount(vcount), .wave_prof(wave_prof), .rgb(rgb)
    );

endmodule

//--- tests/tb_display.sv
module tb_display;
    timeunit 1ns;
    timeprecision 1ps;
    import display_pkg::*;

    localparam int max_cycles = 2000;  // far above the directed run length

    logic                vclock;
    logic                reset;
    logic                vsync;
    logic [hcount_w-1:0] hcount;
    logic [vcount_w-1:0] vcount;
    logic [vcount_w-1:0] wave_prof;
    logic [vcount_w-1:0] p_vpos;
    obj_word_t           obj_words [num_obj];
    logic [9:0]          score;
    logic [1:0]          health;
    logic [rgb_w-1:0]    rgb;
    digits_t             digits;

    string       test_name = "none";
    logic [15:0] lfsr      = 16'd89;  // seed
    int          cycles    = 0;

    display_top dut_i (
        .vclock(vclock), .reset(reset), .vsync(vsync),
        .hcount(hcount), .vcount(vcount), .wave_prof(wave_prof), .p_vpos(p_vpos),
        .obj_words(obj_words), .score(score), .health(health),
        .rgb(rgb), .digits(digits)
    );

    //////////////////////////////////////////////////
    // clock and run limit

    initial begin
        vclock = 1'b0;
        forever #2 vclock = ~vclock;  // 4 ns period
    end

    always @(posedge vclock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run went past %0d clock cycles", max_cycles);
            $display("Some tests failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // helpers, all enter and leave on a falling edge

    // 16 bit galois lfsr, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [9:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[8:0], lfsr[0]};  // msb first
        end
    endtask

    task automatic check_value(input string label, input logic [11:0] expected,
                               input logic [11:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %h, actual %h",
                     test_name, label, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic obj_word_t make_obj(input logic [1:0] kind,
                                           input logic [hcount_w-1:0] x,
                                           input logic [vcount_w-1:0] y);
        make_obj = '{kind: kind, x: x, y: y};
    endfunction

    task automatic clear_objects();
        for (int i = 0; i < num_obj; i++) begin
            obj_words[i] = '0;
        end
    endtask

    // one low cycle, latch happens on the edge inside it
    task automatic pulse_vsync();
        vsync = 1'b0;
        @(negedge vclock);
        vsync = 1'b1;
        @(negedge vclock);  // one high cycle before any next fall
    endtask

    // hold the counters, color comes out two clocks later
    task automatic probe_pixel(input logic [hcount_w-1:0] hc, input logic [vcount_w-1:0] vc,
                               input logic [rgb_w-1:0] exp_rgb, input string label);
        hcount = hc;
        vcount = vc;
        repeat (2) @(negedge vclock);
        check_value(label, exp_rgb, rgb);
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic reset_behavior();
        test_name = "reset";
        repeat (10) begin
            @(negedge vclock);
            check_value("rgb in reset", 12'h000, rgb);
        end
        reset = 1'b0;
        @(negedge vclock);
        check_value("rgb after reset", 12'h000, rgb);
        check_value("digits after reset", 12'h000, digits);
    endtask

    task automatic frame_latch();
        test_name = "frame_latch";
        wave_prof = 0;    // everything below row 0 is water
        p_vpos    = 600;  // player out of the way
        health    = 3;
        clear_objects();
        obj_words[0] = make_obj(kind_coll, 300, 200);
        obj_words[1] = make_obj(kind_shark, 400, 300);
        obj_words[2] = make_obj(2'd2, 500, 100);  // kinds 2 and 3 invisible
        obj_words[3] = make_obj(2'd3, 600, 100);
        pulse_vsync();
        probe_pixel(300, 200, color_coll, "coll corner");
        probe_pixel(314, 215, color_coll, "coll far corner");
        probe_pixel(315, 200, color_water, "right of coll");
        probe_pixel(300, 216, color_water, "below coll");
        probe_pixel(299, 200, color_water, "left of coll");
        probe_pixel(400, 300, color_shark, "shark corner");
        probe_pixel(439, 319, color_shark, "shark far corner");
        probe_pixel(440, 300, color_water, "right of shark");
        probe_pixel(400, 320, color_water, "below shark");
        probe_pixel(400, 299, color_water, "above shark");
        probe_pixel(505, 105, color_water, "kind 2 slot");
        probe_pixel(605, 105, color_water, "kind 3 slot");
        // new words mid frame, sprites stay put
        obj_words[0] = make_obj(kind_coll, 700, 250);
        obj_words[1] = make_obj(kind_shark, 800, 350);
        probe_pixel(300, 200, color_coll, "old coll mid frame");
        probe_pixel(700, 250, color_water, "new coll mid frame");
        probe_pixel(800, 350, color_water, "new shark mid frame");
        pulse_vsync();
        probe_pixel(700, 250, color_coll, "moved coll corner");
        probe_pixel(714, 265, color_coll, "moved coll far corner");
        probe_pixel(715, 250, color_water, "right of moved coll");
        probe_pixel(700, 249, color_water, "above moved coll");
        probe_pixel(800, 350, color_shark, "moved shark corner");
        probe_pixel(839, 369, color_shark, "moved shark far corner");
        probe_pixel(840, 350, color_water, "right of moved shark");
        probe_pixel(800, 370, color_water, "below moved shark");
        probe_pixel(300, 200, color_water, "old coll gone");
    endtask

    task automatic priority_order();
        test_name = "priority";
        wave_prof = 0;
        p_vpos    = 100;  // player box 10..54 x 100..139
        health    = 3;
        clear_objects();
        obj_words[0] = make_obj(kind_coll, 50, 130);   // over the player
        obj_words[1] = make_obj(kind_shark, 60, 140);  // over the collectable
        obj_words[2] = make_obj(kind_shark, 40, 50);   // over heart 0
        pulse_vsync();
        probe_pixel(52, 135, color_char, "char over coll");
        probe_pixel(62, 142, color_coll, "coll over shark");
        probe_pixel(70, 150, color_shark, "shark alone");
        probe_pixel(45, 55, color_shark, "shark over heart");
        probe_pixel(30, 30, color_heart_full, "heart alone");
        probe_pixel(12, 105, color_char, "char alone");
    endtask

    task automatic heart_fill();
        logic [hcount_w-1:0] hx;
        logic [vcount_w-1:0] hy;
        logic [rgb_w-1:0]    expected;
        test_name = "hearts";
        p_vpos    = 400;
        clear_objects();
        hy = vcount_w'(heart_y + heart_h / 2);
        for (int h = 0; h < 4; h++) begin
            health = 2'(h);
            pulse_vsync();
            for (int k = 0; k < num_hearts; k++) begin
                hx       = hcount_w'(heart_x0 + k * heart_dx + heart_w / 2);
                expected = (h > k) ? color_heart_full : color_heart_empty;  // full while health > k
                probe_pixel(hx, hy, expected, $sformatf("health %0d heart %0d", h, k));
            end
        end
    endtask

    task automatic background_split();
        test_name = "background";
        p_vpos    = 400;
        clear_objects();
        pulse_vsync();
        wave_prof = 200;
        probe_pixel(600, 200, color_sky, "on wave line");
        probe_pixel(600, 199, color_sky, "just above wave");
        probe_pixel(600, 201, color_water, "just below wave");
        probe_pixel(600, 0, color_sky, "top row");
        wave_prof = 0;
        probe_pixel(600, 0, color_sky, "top row on zero wave");
        probe_pixel(600, 1, color_water, "second row on zero wave");
    endtask

    task automatic check_score(input logic [9:0] s);
        int         c;
        logic [11:0] expected;
        score = s;
        pulse_vsync();
        c        = (int'(s) > score_max) ? score_max : int'(s);  // clamp
        expected = {4'(c / 100), 4'((c / 10) % 10), 4'(c % 10)};
        check_value($sformatf("score %0d", s), expected, digits);
    endtask

    task automatic score_digits();
        logic [9:0] s;
        test_name = "score_digits";
        for (int i = 0; i < 20; i++) begin
            draw_bits(10, s);
            check_score(s);
        end
        // clamp edges
        check_score(10'd999);
        check_score(10'd1000);
        check_score(10'd1023);
        check_score(10'd0);
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        reset     = 1'b1;
        vsync     = 1'b1;  // idle high
        hcount    = '0;
        vcount    = '0;
        wave_prof = '0;
        p_vpos    = '0;
        score     = '0;
        health    = '0;
        clear_objects();

        reset_behavior();
        frame_latch();
        priority_order();
        heart_fill();
        background_split();
        score_digits();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- filelist.f
hdl/display_pkg.sv
hdl/frame_decode.sv
hdl/sprite_hit_array.sv
hdl/pixel_compose.sv
hdl/display_top.sv
tests/tb_display.sv

//--- run.sh
#!/bin/sh
# build and run the display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_display -f filelist.f

result=$(./obj_dir/Vtb_display) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
